/* project.f */
+incdir+source
source/sptc_ctrl_pkg.sv
source/sptc_data_pkg.sv
source/delay_unit.sv
source/compact_unit.sv
source/sp_core.sv
source/mm_adder.sv
source/sptc_ctrl.sv
verif/tb_clock_gen.sv
verif/sptc_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module sptc_tb -Mdir obj_dir -f project.f \
  && ./obj_dir/Vsptc_tb \
  || exit 1

/* verif/sptc_tb.sv */
`timescale 1ns/100ps
`include "sptc_config.svh"

module sptc_tb;
  import sptc_ctrl_pkg::*;
  import sptc_data_pkg::*;

  // value modes
  localparam int VM_RANDOM = 0;
  localparam int VM_MAX    = 1;
  localparam int VM_MIN    = 2;
  localparam int VM_MIXED  = 3;
  // index modes
  localparam int IM_ASC    = 0;
  localparam int IM_RANDOM = 1;

  localparam int NUM_CASES      = 6;
  localparam int TIMEOUT_CYCLES = NUM_CASES * 100 + 20;

  // case table, one column per array
  // value mode, index mode, reload A
  int tab_vmode  [NUM_CASES] = '{VM_RANDOM, VM_RANDOM, VM_MAX, VM_MIN, VM_MIXED, VM_RANDOM};
  int tab_imode  [NUM_CASES] = '{IM_ASC, IM_RANDOM, IM_ASC, IM_RANDOM, IM_RANDOM, IM_RANDOM};
  bit tab_load_a [NUM_CASES] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

  logic                               reset;
  logic                               clk;
  logic                               load_valid;
  load_target_e                       load_target;
  elem_t [`SPTC_N-1:0]                load_data;
  idx_t [`SPTC_A_NZ-1:0]              load_index;
  logic                               start;
  sptc_state_e                        state;
  logic                               result_valid;
  logic [$clog2(`SPTC_M)-1:0]         result_row;
  acc_t [`SPTC_N-1:0]                 result_data;

  // operand images and expected product
  elem_t tb_a_val [`SPTC_M][`SPTC_A_NZ];
  idx_t  tb_a_idx [`SPTC_M][`SPTC_A_NZ];
  elem_t tb_b     [`SPTC_K][`SPTC_N];
  acc_t  ref_s    [`SPTC_M][`SPTC_N];

  logic [31:0] lfsr_q;
  int          total_rows = 0;
  int          cycle_cnt = 0;

  tb_clock_gen u_clock_gen (
    .reset (reset),
    .clk   (clk)
  );

  sptc_ctrl uut (
    .reset        (reset),
    .clk          (clk),
    .load_valid   (load_valid),
    .load_target  (load_target),
    .load_data    (load_data),
    .load_index   (load_index),
    .start        (start),
    .state        (state),
    .result_valid (result_valid),
    .result_row   (result_row),
    .result_data  (result_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // error handling and random source
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    assert (got == exp) else begin
      stop_on_error($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // galois form, right shift
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic elem_t pick_value(input int mode, input int r, input int c);
    elem_t mag;
    case (mode)
      VM_MAX: pick_value = elem_t'(127);
      VM_MIN: pick_value = elem_t'(-128);
      VM_MIXED: begin
        // checkerboard of signs
        mag = elem_t'(take_bits(7));
        pick_value = ((r + c) % 2 == 1) ? -mag : mag;
      end
      default: pick_value = elem_t'(take_bits(8));
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and reference
  ////////////////////////////////////////////////////////////////////////////

  task automatic make_operands(input int t);
    idx_t first;
    idx_t second;
    for (int r = 0; r < `SPTC_K; r++) begin
      for (int c = 0; c < `SPTC_N; c++) begin
        tb_b[r][c] = pick_value(tab_vmode[t], r, c);
      end
    end
    if (tab_load_a[t]) begin
      for (int r = 0; r < `SPTC_M; r++) begin
        for (int g = 0; g < 2; g++) begin
          tb_a_val[r][2*g]   = pick_value(tab_vmode[t], r, 2*g);
          tb_a_val[r][2*g+1] = pick_value(tab_vmode[t], r, 2*g+1);
          if (tab_imode[t] == IM_ASC) begin
            first  = idx_t'(r % 2);
            second = first + 2'd2;
          end else begin
            // two distinct slots, any order
            first  = idx_t'(take_bits(2));
            second = idx_t'(take_bits(2));
            if (second == first) begin
              second = first + 2'd1;
            end
          end
          tb_a_idx[r][2*g]   = first;
          tb_a_idx[r][2*g+1] = second;
        end
      end
    end
  endtask

  task automatic build_reference();
    elem_t dense [`SPTC_M][`SPTC_K];
    acc_t  sum;
    for (int m = 0; m < `SPTC_M; m++) begin
      for (int k = 0; k < `SPTC_K; k++) begin
        dense[m][k] = '0;
      end
      // kept value j lands in column 4*(j/2) + index
      for (int j = 0; j < `SPTC_A_NZ; j++) begin
        dense[m][4 * (j / 2) + int'(tb_a_idx[m][j])] = tb_a_val[m][j];
      end
    end
    for (int m = 0; m < `SPTC_M; m++) begin
      for (int n = 0; n < `SPTC_N; n++) begin
        sum = '0;
        for (int k = 0; k < `SPTC_K; k++) begin
          sum = sum + acc_t'(dense[m][k]) * acc_t'(tb_b[k][n]);
        end
        ref_s[m][n] = sum;
      end
    end
  endtask

  task automatic load_a_rows();
    for (int r = 0; r < `SPTC_M; r++) begin
      @(posedge reset);
      load_valid  <= 1'b1;
      load_target <= tgt_a;
      for (int j = 0; j < `SPTC_A_NZ; j++) begin
        load_data[j]  <= tb_a_val[r][j];
        load_index[j] <= tb_a_idx[r][j];
      end
      for (int j = `SPTC_A_NZ; j < `SPTC_N; j++) begin
        load_data[j] <= '0;
      end
    end
  endtask

  task automatic load_b_rows();
    for (int r = 0; r < `SPTC_K; r++) begin
      @(posedge reset);
      load_valid  <= 1'b1;
      load_target <= tgt_b;
      load_index  <= '0;
      for (int c = 0; c < `SPTC_N; c++) begin
        load_data[c] <= tb_b[r][c];
      end
    end
  endtask

  task automatic pulse_start();
    @(posedge reset);
    load_valid <= 1'b0;
    start      <= 1'b1;
    @(posedge reset);
    start <= 1'b0;
  endtask

  // outputs are sampled on the falling edge, away from the drive edge
  task automatic collect_results();
    int rows;
    rows = 0;
    while (rows < `SPTC_M) begin
      @(negedge reset);
      if (result_valid) begin
        check_value("result_row", result_row, rows);
        for (int c = 0; c < `SPTC_N; c++) begin
          check_value($sformatf("result_data[%0d] (row %0d)", c, rows),
                      result_data[c], ref_s[rows][c]);
        end
        rows++;
      end
    end
    @(negedge reset);
    check_value("result_valid", result_valid, 0);
    check_value("state", state, st_idle);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  // every row the DUT emits, stray ones between runs included
  always @(negedge reset) begin
    if (result_valid) begin
      total_rows = total_rows + 1;
    end
  end

  always @(posedge reset) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("timeout after %0d cycles, %0d result rows seen",
                              cycle_cnt, total_rows));
    end
  end

  initial begin
    load_valid  = 1'b0;
    load_target = tgt_a;
    load_data   = '0;
    load_index  = '0;
    start       = 1'b0;
    lfsr_q      = 32'hdd0e_904a;

    @(negedge clk);
    @(negedge reset);
    check_value("state", state, st_idle);
    check_value("result_valid", result_valid, 0);

    for (int t = 0; t < NUM_CASES; t++) begin
      make_operands(t);
      build_reference();
      if (tab_load_a[t]) begin
        load_a_rows();
      end
      load_b_rows();
      pulse_start();
      collect_results();
    end

    if (total_rows == NUM_CASES * `SPTC_M) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d result rows were seen where %0d were expected",
                              total_rows, NUM_CASES * `SPTC_M));
    end
  end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic reset,
  output logic clk
);

  // 8 ns clock on the port named reset
  initial begin
    reset = 1'b0;
    forever begin
      #4 reset = ~reset;
    end
  end

  // active-high reset on the port named clk, held for two rising edges
  initial begin
    clk = 1'b1;
    repeat (2) @(posedge reset);
    @(negedge reset);
    clk = 1'b0;
  end

endmodule

/* source/sptc_ctrl.sv */
`timescale 1ns/100ps
`include "sptc_config.svh"

module sptc_ctrl (
  input  logic                                        reset,
  input  logic                                        clk,
  input  logic                                        load_valid,
  input  sptc_ctrl_pkg::load_target_e                 load_target,
  input  sptc_data_pkg::elem_t [`SPTC_N-1:0]          load_data,
  input  sptc_data_pkg::idx_t [`SPTC_A_NZ-1:0]        load_index,
  input  logic                                        start,
  output sptc_ctrl_pkg::sptc_state_e                  state,
  output logic                                        result_valid,
  output logic [$clog2(`SPTC_M)-1:0]                  result_row,
  output sptc_data_pkg::acc_t [`SPTC_N-1:0]           result_data
);
  import sptc_ctrl_pkg::*;
  import sptc_data_pkg::*;

  localparam int M_T = `SPTC_M / `SPTC_M_TILE;
  localparam int K_T = `SPTC_K / `SPTC_K_TILE_B;
  localparam int N_T = `SPTC_N / `SPTC_N_TILE;

  // operand memories
  elem_t                 a_val [`SPTC_M][`SPTC_A_NZ];
  idx_t                  a_idx [`SPTC_M][`SPTC_A_NZ];
  elem_t [`SPTC_N-1:0]   b_mem [`SPTC_K];

  logic [$clog2(`SPTC_M)-1:0] a_row_q;
  logic [$clog2(`SPTC_K)-1:0] b_row_q;
  logic [$clog2(`SPTC_M)-1:0] res_cnt_q;
  tile_tag_t                  cur_q;
  logic                       load_wr;
  logic                       last_issue;

  // issue register
  logic                                             issue_valid;
  elem_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0]     iss_a_val;
  idx_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0]      iss_a_idx;
  elem_t [`SPTC_K_TILE_B-1:0][`SPTC_N_TILE-1:0]     iss_b;
  tile_tag_t                                        iss_tag;

  // pipeline
  logic                                                        core_in_valid;
  elem_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0]                core_a;
  elem_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0][`SPTC_N_TILE-1:0] cpt_b;
  acc_t [`SPTC_M_TILE-1:0][`SPTC_N_TILE-1:0]                   core_psum;
  logic                                                        core_valid;
  tile_tag_t                                                   tag_dly;
  logic                                                        tag_valid;

  // the first beat in idle already lands in memory
  assign load_wr = load_valid && (state == st_idle || state == st_load);

  assign last_issue = (cur_q.m == M_T - 1) && (cur_q.k == K_T - 1) && (cur_q.n == N_T - 1);

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      state       <= st_idle;
      a_row_q     <= '0;
      b_row_q     <= '0;
      cur_q       <= '0;
      res_cnt_q   <= '0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= (state == st_compute);
      if (result_valid) begin
        res_cnt_q <= res_cnt_q + 1'b1;
      end
      if (load_wr) begin
        if (load_target == tgt_a) begin
          a_row_q <= a_row_q + 1'b1;
        end else begin
          b_row_q <= b_row_q + 1'b1;
        end
      end
      case (state)
        st_idle, st_load: begin
          if (start) begin
            state     <= st_compute;
            a_row_q   <= '0;
            b_row_q   <= '0;
            cur_q     <= '0;
            res_cnt_q <= '0;
          end else if (load_valid) begin
            state <= st_load;
          end
        end
        st_compute: begin
          // n inner, then k, then m
          if (cur_q.n == N_T - 1) begin
            cur_q.n <= '0;
            if (cur_q.k == K_T - 1) begin
              cur_q.k <= '0;
              cur_q.m <= cur_q.m + 1'b1;
            end else begin
              cur_q.k <= cur_q.k + 1'b1;
            end
          end else begin
            cur_q.n <= cur_q.n + 1'b1;
          end
          if (last_issue) begin
            state <= st_drain;
          end
        end
        st_drain: begin
          if (result_valid && res_cnt_q == `SPTC_M - 1) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memories and tile fetch
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge reset) begin
    if (load_wr) begin
      if (load_target == tgt_a) begin
        for (int j = 0; j < `SPTC_A_NZ; j++) begin
          a_val[a_row_q][j] <= load_data[j];
          a_idx[a_row_q][j] <= load_index[j];
        end
      end else begin
        b_mem[b_row_q] <= load_data;
      end
    end
  end

  always_ff @(posedge reset) begin
    for (int r = 0; r < `SPTC_M_TILE; r++) begin
      for (int s = 0; s < `SPTC_K_TILE_A; s++) begin
        iss_a_val[r][s] <= a_val[cur_q.m * `SPTC_M_TILE + r][cur_q.k * `SPTC_K_TILE_A + s];
        iss_a_idx[r][s] <= a_idx[cur_q.m * `SPTC_M_TILE + r][cur_q.k * `SPTC_K_TILE_A + s];
      end
    end
    for (int i = 0; i < `SPTC_K_TILE_B; i++) begin
      for (int c = 0; c < `SPTC_N_TILE; c++) begin
        iss_b[i][c] <= b_mem[cur_q.k * `SPTC_K_TILE_B + i][cur_q.n * `SPTC_N_TILE + c];
      end
    end
    iss_tag <= cur_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  delay_unit #(
    .WIDTH ($bits(iss_a_val)),
    .DEPTH (`SPTC_CPT_DEPTH)
  ) u_align_a (
    .reset     (reset),
    .clk       (clk),
    .in_valid  (issue_valid),
    .in_data   (iss_a_val),
    .out_valid (core_in_valid),
    .out_data  (core_a)
  );

  delay_unit #(
    .WIDTH ($bits(tile_tag_t)),
    .DEPTH (`SPTC_TAG_DEPTH)
  ) u_align_tag (
    .reset     (reset),
    .clk       (clk),
    .in_valid  (issue_valid),
    .in_data   (iss_tag),
    .out_valid (tag_valid),
    .out_data  (tag_dly)
  );

  compact_unit u_compact_unit (
    .reset     (reset),
    .clk       (clk),
    .in_index  (iss_a_idx),
    .in_b_tile (iss_b),
    .out_b     (cpt_b)
  );

  sp_core u_sp_core (
    .reset      (reset),
    .clk        (clk),
    .in_valid   (core_in_valid),
    .in_a       (core_a),
    .in_b       (cpt_b),
    .psum       (core_psum),
    .psum_valid (core_valid)
  );

  mm_adder u_mm_adder (
    .reset        (reset),
    .clk          (clk),
    .psum_valid   (core_valid),
    .psum         (core_psum),
    .tag          (tag_dly),
    .result_valid (result_valid),
    .result_row   (result_row),
    .result_data  (result_data)
  );

  // loads and starts only while idle or loading
  a_no_load_busy: assert property (@(posedge reset) disable iff (clk)
    (state == st_compute || state == st_drain) |-> !load_valid);

  a_no_start_busy: assert property (@(posedge reset) disable iff (clk)
    (state == st_compute || state == st_drain) |-> !start);

  // tag path and core path stay in step
  a_tag_aligned: assert property (@(posedge reset) disable iff (clk)
    tag_valid == core_valid);

endmodule

/* source/mm_adder.sv */
`timescale 1ns/100ps
`include "sptc_config.svh"

module mm_adder (
  input  logic                                                      reset,
  input  logic                                                      clk,
  input  logic                                                      psum_valid,
  input  sptc_data_pkg::acc_t [`SPTC_M_TILE-1:0][`SPTC_N_TILE-1:0]  psum,
  input  sptc_data_pkg::tile_tag_t                                  tag,
  output logic                                                      result_valid,
  output logic [$clog2(`SPTC_M)-1:0]                                result_row,
  output sptc_data_pkg::acc_t [`SPTC_N-1:0]                         result_data
);
  import sptc_data_pkg::*;

  localparam int K_T = `SPTC_K / `SPTC_K_TILE_B;
  localparam int N_T = `SPTC_N / `SPTC_N_TILE;

  acc_t [`SPTC_N-1:0] acc_q   [`SPTC_M_TILE];
  acc_t [`SPTC_N-1:0] acc_nxt [`SPTC_M_TILE];
  acc_t [`SPTC_N-1:0] rbuf_q  [`SPTC_M_TILE];

  logic                             last_tile;
  logic                             busy_q;
  logic [$clog2(`SPTC_M_TILE)-1:0]  send_q;
  logic [TAG_M_W-1:0]               buf_m_q;

  assign last_tile = psum_valid && (tag.k == K_T - 1) && (tag.n == N_T - 1);

  // first k step overwrites, later ones accumulate
  always_comb begin
    acc_nxt = acc_q;
    for (int r = 0; r < `SPTC_M_TILE; r++) begin
      for (int c = 0; c < `SPTC_N_TILE; c++) begin
        if (tag.k == '0) begin
          acc_nxt[r][tag.n * `SPTC_N_TILE + c] = psum[r][c];
        end else begin
          acc_nxt[r][tag.n * `SPTC_N_TILE + c] = acc_q[r][tag.n * `SPTC_N_TILE + c] + psum[r][c];
        end
      end
    end
  end

  always_ff @(posedge reset) begin
    if (psum_valid) begin
      acc_q <= acc_nxt;
    end
    // finished block moves out so the next one can start
    if (last_tile) begin
      rbuf_q <= acc_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // row streaming
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      busy_q  <= 1'b0;
      send_q  <= '0;
      buf_m_q <= '0;
    end else if (last_tile) begin
      busy_q  <= 1'b1;
      send_q  <= '0;
      buf_m_q <= tag.m;
    end else if (busy_q) begin
      send_q <= send_q + 1'b1;
      if (send_q == `SPTC_M_TILE - 1) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign result_valid = busy_q;
  assign result_row   = {buf_m_q, send_q};
  assign result_data  = rbuf_q[send_q];

  // buffer is free, or its last row goes out this cycle
  a_buf_free: assert property (@(posedge reset) disable iff (clk)
    last_tile |-> (!busy_q || send_q == `SPTC_M_TILE - 1));

endmodule

/* source/sp_core.sv */
`timescale 1ns/100ps
`include "sptc_config.svh"

module sp_core (
  input  logic                                                       reset,
  input  logic                                                       clk,
  input  logic                                                       in_valid,
  input  sptc_data_pkg::elem_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0] in_a,
  input  sptc_data_pkg::elem_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0][`SPTC_N_TILE-1:0] in_b,
  output sptc_data_pkg::acc_t [`SPTC_M_TILE-1:0][`SPTC_N_TILE-1:0]   psum,
  output logic                                                       psum_valid
);
  import sptc_data_pkg::*;

  acc_t [`SPTC_M_TILE-1:0][`SPTC_N_TILE-1:0] psum_nxt;

  // one multiplier per kept value and output column
  always_comb begin
    for (int r = 0; r < `SPTC_M_TILE; r++) begin
      for (int c = 0; c < `SPTC_N_TILE; c++) begin
        psum_nxt[r][c] = '0;
        for (int s = 0; s < `SPTC_K_TILE_A; s++) begin
          // widen first so -128 * -128 stays exact
          psum_nxt[r][c] = psum_nxt[r][c] + acc_t'(in_a[r][s]) * acc_t'(in_b[r][s][c]);
        end
      end
    end
  end

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      psum_valid <= 1'b0;
    end else begin
      psum_valid <= in_valid;
    end
  end

  always_ff @(posedge reset) begin
    if (in_valid) begin
      psum <= psum_nxt;
    end
  end

endmodule

/* source/compact_unit.sv */
`timescale 1ns/100ps
`include "sptc_config.svh"

module compact_unit (
  input  logic                                                         reset,
  input  logic                                                         clk,
  input  sptc_data_pkg::idx_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0]   in_index,
  input  sptc_data_pkg::elem_t [`SPTC_K_TILE_B-1:0][`SPTC_N_TILE-1:0]  in_b_tile,
  output sptc_data_pkg::elem_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0][`SPTC_N_TILE-1:0] out_b
);
  import sptc_data_pkg::*;

  // dense columns per sparse group, and kept values per group
  localparam int GRP_W  = 1 << `SPTC_DW_IDX;
  localparam int GRP_NZ = GRP_W / `SPTC_EXPAND;

  elem_t [`SPTC_M_TILE-1:0][`SPTC_K_TILE_A-1:0][`SPTC_N_TILE-1:0] gather;

  // slot s sits in group s / GRP_NZ, its index picks the row inside it
  always_comb begin
    for (int r = 0; r < `SPTC_M_TILE; r++) begin
      for (int s = 0; s < `SPTC_K_TILE_A; s++) begin
        for (int c = 0; c < `SPTC_N_TILE; c++) begin
          gather[r][s][c] = in_b_tile[(s / GRP_NZ) * GRP_W + int'(in_index[r][s])][c];
        end
      end
    end
  end

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      out_b <= '0;
    end else begin
      out_b <= gather;
    end
  end

endmodule

/* source/delay_unit.sv */
`timescale 1ns/100ps

module delay_unit #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 1
) (
  input  logic             reset,
  input  logic             clk,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data
);

  logic [DEPTH-1:0] vld_q;
  logic [WIDTH-1:0] dat_q [DEPTH];

  // valid chain
  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // data chain
  always_ff @(posedge reset) begin
    dat_q[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      dat_q[i] <= dat_q[i-1];
    end
  end

  assign out_valid = vld_q[DEPTH-1];
  assign out_data  = dat_q[DEPTH-1];

endmodule

/* source/sptc_data_pkg.sv */
`include "sptc_config.svh"

package sptc_data_pkg;

  // tile counter widths
  localparam int TAG_M_W = $clog2(`SPTC_M / `SPTC_M_TILE);
  localparam int TAG_K_W = $clog2(`SPTC_K / `SPTC_K_TILE_B);
  localparam int TAG_N_W = $clog2(`SPTC_N / `SPTC_N_TILE);

  typedef logic signed [`SPTC_DW_MUL-1:0] elem_t;
  typedef logic [`SPTC_DW_IDX-1:0] idx_t;
  typedef logic signed [`SPTC_DW_ADD-1:0] acc_t;

  // position of one tile operation in the m/k/n walk
  typedef struct packed {
    logic [TAG_M_W-1:0] m;
    logic [TAG_K_W-1:0] k;
    logic [TAG_N_W-1:0] n;
  } tile_tag_t;

endpackage

/* source/sptc_ctrl_pkg.sv */
package sptc_ctrl_pkg;

  // sequencer state, also visible at the top-level port
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_load    = 2'd1,
    st_compute = 2'd2,
    st_drain   = 2'd3
  } sptc_state_e;

  // which memory a load beat writes
  typedef enum logic {
    tgt_a = 1'b0,
    tgt_b = 1'b1
  } load_target_e;

endpackage

/* source/sptc_config.svh */
`ifndef SPTC_CONFIG_SVH
`define SPTC_CONFIG_SVH

// matrix dimensions
`define SPTC_M         8
`define SPTC_K         8
`define SPTC_N         8

// tile shape per issue
`define SPTC_M_TILE    4
`define SPTC_N_TILE    2
`define SPTC_K_TILE_B  4

// 2:4 structured sparsity
`define SPTC_EXPAND    2
`define SPTC_K_TILE_A  2
`define SPTC_A_NZ      4

// datapath widths
`define SPTC_DW_MUL    8
`define SPTC_DW_IDX    2
`define SPTC_DW_ADD    32

// pipeline depths, in cycles after issue
`define SPTC_CPT_DEPTH 1
`define SPTC_TAG_DEPTH 2

`endif
